// ==== hw/stepper_pkg.sv ====
package stepper_pkg;

  // Command codes carried in the header byte
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_clk_divisor = 8'h02;
  localparam logic [7:0] cmd_motor_enable = 8'h0a;
  localparam logic [7:0] cmd_motorconfig = 8'h10;
  localparam logic [7:0] cmd_api_version = 8'hfe;

  // Firmware interface version
  localparam logic [7:0] version_major = 8'd0;
  localparam logic [7:0] version_minor = 8'd1;
  localparam logic [7:0] version_patch = 8'd3;

  // Power-up configuration
  localparam logic [2:0] reset_microsteps = 3'd2;
  localparam logic [7:0] reset_current = 8'd140;
  localparam logic [7:0] reset_clock_divisor = 8'd40;

  // Number of move slots between decoder and DDA
  localparam int move_buffer_depth = 2;

  // One SPI word, read as a header on the first word of a message
  // and as raw data on every payload word
  typedef union packed {
    struct packed {
      logic [7:0] cmd;
      logic [55:0] arg;
    } header;
    logic [63:0] raw;
  } spi_word_t;

endpackage

// ==== hw/spi_word.sv ====
`timescale 1ns/1ns

module spi_word (
  input logic CLK,
  input logic resetn,
  input logic sck,
  input logic cs,
  input logic copi,
  input stepper_pkg::spi_word_t reply_data,
  output logic cipo,
  output stepper_pkg::spi_word_t word_data,
  output logic word_strobe
);

  // Two sync stages plus one history stage for edge detection
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;

  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic cs_active;

  logic [63:0] rx_shift;
  logic [63:0] tx_shift;
  logic [1:0] rise_dly;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_rise = cs_q[1] & ~cs_q[2];
  assign cs_fall = ~cs_q[1] & cs_q[2];
  assign cs_active = ~cs_q[1];

  // MSB of the outgoing word is always on the pin
  assign cipo = tx_shift[63];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q <= 3'b000;
      cs_q <= 3'b111;
      copi_q <= 2'b00;
    end else begin
      sck_q <= {sck_q[1:0], sck};
      cs_q <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  // Receive side, mode 0 samples on the rising sck edge
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
    end
  end

  // Transmit side, reply captured when the host opens the word
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= reply_data.raw;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  // Word handed over three cycles after cs is seen high again
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rise_dly <= 2'b00;
      word_strobe <= 1'b0;
    end else begin
      rise_dly <= {rise_dly[0], cs_rise};
      word_strobe <= rise_dly[1];
    end
  end

  always_ff @(posedge CLK) begin
    if (rise_dly[1]) begin
      word_data.raw <= rx_shift;
    end
  end

  // Each sck phase lasts at least four CLK cycles
  a_sck_phase : assert property (
    @(posedge CLK) disable iff (!resetn)
    (sck_rise || sck_fall) |=> !(sck_rise || sck_fall) [*3]
  );

endmodule

// ==== hw/command_decoder.sv ====
`timescale 1ns/1ns

module command_decoder #(
  parameter int motor_count = 2,
  parameter int move_duration_bits = 32
) (
  input logic CLK,
  input logic resetn,
  input stepper_pkg::spi_word_t word_data,
  input logic word_strobe,
  input logic move_index,
  input logic signed [31:0] step_count [motor_count],
  output stepper_pkg::spi_word_t reply_data,
  output logic [motor_count-1:0] enable,
  output logic [2:0] microsteps,
  output logic [7:0] current,
  output logic [7:0] clock_divisor,
  output logic [stepper_pkg::move_buffer_depth-1:0] stepready,
  output logic [move_duration_bits-1:0] slot_duration [stepper_pkg::move_buffer_depth],
  output logic [motor_count-1:0] slot_dir [stepper_pkg::move_buffer_depth],
  output logic signed [63:0] slot_increment [stepper_pkg::move_buffer_depth][motor_count],
  output logic signed [63:0] slot_incrementincrement
    [stepper_pkg::move_buffer_depth][motor_count]
);

  // Header, duration, then two words per axis
  localparam logic [7:0] last_word = 8'(2 * motor_count + 1);
  localparam int pending_bits = $clog2(stepper_pkg::move_buffer_depth + 1);

  logic [7:0] msg_header;
  logic [7:0] word_count;
  logic write_slot;
  logic signed [31:0] snap [motor_count];

  logic in_message;
  logic header_word;
  logic move_header;
  logic move_word;
  logic move_commit;

  // Multi-word commands keep the header until their last word
  assign in_message = (msg_header == stepper_pkg::cmd_coordinated_step) ||
                      (msg_header == stepper_pkg::cmd_api_version);
  assign header_word = word_strobe && !in_message;
  assign move_header = header_word &&
                       (word_data.header.cmd == stepper_pkg::cmd_coordinated_step);
  assign move_word = word_strobe && (msg_header == stepper_pkg::cmd_coordinated_step);
  assign move_commit = move_word && (word_count == last_word);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      msg_header <= 8'd0;
      word_count <= 8'd0;
      write_slot <= 1'b0;
      stepready <= '0;
      reply_data.raw <= '0;
      enable <= '0;
      microsteps <= stepper_pkg::reset_microsteps;
      current <= stepper_pkg::reset_current;
      clock_divisor <= stepper_pkg::reset_clock_divisor;
    end else if (word_strobe) begin
      reply_data.raw <= '0;
      if (!in_message) begin
        msg_header <= word_data.header.cmd;
        word_count <= 8'd1;
        case (word_data.header.cmd)
          stepper_pkg::cmd_motor_enable: begin
            enable <= word_data.header.arg[motor_count-1:0];
          end
          stepper_pkg::cmd_motorconfig: begin
            current <= word_data.header.arg[15:8];
            microsteps <= word_data.header.arg[2:0];
          end
          stepper_pkg::cmd_clk_divisor: begin
            clock_divisor <= word_data.header.arg[7:0];
          end
          stepper_pkg::cmd_api_version: begin
            reply_data.raw[23:0] <= {stepper_pkg::version_major,
                                     stepper_pkg::version_minor,
                                     stepper_pkg::version_patch};
          end
          default: begin
            reply_data.raw <= '0;
          end
        endcase
      end else if (msg_header == stepper_pkg::cmd_coordinated_step) begin
        word_count <= word_count + 8'd1;
        // Snapshots go back while the host streams the axis words
        if (word_count == 8'd1) begin
          reply_data.raw <= 64'(snap[0]);
        end
        for (int k = 0; k < motor_count - 1; k++) begin
          if (word_count == 8'(2 * k + 3)) begin
            reply_data.raw <= 64'(snap[k+1]);
          end
        end
        if (move_commit) begin
          stepready[write_slot] <= ~stepready[write_slot];
          write_slot <= write_slot + 1'b1;
          msg_header <= 8'd0;
          word_count <= 8'd0;
        end
      end else begin
        // Trailing word of API version
        msg_header <= 8'd0;
        word_count <= 8'd0;
      end
    end
  end

  // Slot contents and encoder snapshots
  always_ff @(posedge CLK) begin
    if (move_header) begin
      slot_dir[write_slot] <= word_data.header.arg[motor_count-1:0];
      for (int k = 0; k < motor_count; k++) begin
        snap[k] <= step_count[k];
      end
    end
    if (move_word) begin
      if (word_count == 8'd1) begin
        slot_duration[write_slot] <= word_data.raw[move_duration_bits-1:0];
      end
      for (int k = 0; k < motor_count; k++) begin
        if (word_count == 8'(2 * k + 2)) begin
          slot_increment[write_slot][k] <= word_data.raw;
        end
        if (word_count == 8'(2 * k + 3)) begin
          slot_incrementincrement[write_slot][k] <= word_data.raw;
        end
      end
    end
  end

  // Moves queued but not yet retired by the DDA
  logic [pending_bits-1:0] pending;
  logic move_index_q;
  logic slot_retired;

  assign slot_retired = move_index != move_index_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pending <= '0;
      move_index_q <= 1'b0;
    end else begin
      move_index_q <= move_index;
      case ({move_commit, slot_retired})
        2'b10: pending <= pending + 1'b1;
        2'b01: pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  a_no_overrun : assert property (
    @(posedge CLK) disable iff (!resetn)
    move_header |-> (pending < pending_bits'(stepper_pkg::move_buffer_depth))
  );

endmodule

// ==== hw/dda_fsm.sv ====
`timescale 1ns/1ns

module dda_fsm #(
  parameter int move_duration_bits = 32
) (
  input logic CLK,
  input logic resetn,
  input logic [7:0] clock_divisor,
  input logic [stepper_pkg::move_buffer_depth-1:0] stepready,
  input logic [move_duration_bits-1:0] slot_duration [stepper_pkg::move_buffer_depth],
  output logic dda_tick,
  output logic loading_move,
  output logic executing_move,
  output logic move_done,
  output logic buffer_dtr,
  output logic move_index
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_load = 2'd1;
  localparam logic [1:0] st_exec = 2'd2;
  localparam logic [1:0] st_done = 2'd3;

  logic [1:0] state;
  logic [7:0] div_cnt;
  logic [stepper_pkg::move_buffer_depth-1:0] consumed;
  logic [move_duration_bits-1:0] ticks_left;

  logic next_index;
  logic slot_full;
  logic next_full;

  assign next_index = move_index + 1'b1;
  // Toggle pair differs while the decoder has a move waiting
  assign slot_full = stepready[move_index] != consumed[move_index];
  assign next_full = stepready[next_index] != consumed[next_index];
  assign buffer_dtr = ~&(stepready ^ consumed);

  assign loading_move = state == st_load;
  assign executing_move = state == st_exec;
  assign move_done = state == st_done;

  // Free-running tick, once per clock_divisor cycles
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= 8'd0;
      dda_tick <= 1'b0;
    end else if (div_cnt >= clock_divisor - 8'd1) begin
      div_cnt <= 8'd0;
      dda_tick <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 8'd1;
      dda_tick <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= st_idle;
      consumed <= '0;
      move_index <= 1'b0;
      ticks_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (slot_full) begin
            state <= st_load;
          end
        end
        st_load: begin
          ticks_left <= slot_duration[move_index];
          state <= (slot_duration[move_index] == '0) ? st_done : st_exec;
        end
        st_exec: begin
          if (dda_tick) begin
            ticks_left <= ticks_left - 1'b1;
            if (ticks_left == move_duration_bits'(1)) begin
              state <= st_done;
            end
          end
        end
        default: begin
          // Release the slot and chain straight into the next move
          consumed[move_index] <= ~consumed[move_index];
          move_index <= next_index;
          state <= next_full ? st_load : st_idle;
        end
      endcase
    end
  end

  // Slot in play stays full until the DDA releases it
  a_slot_held : assert property (
    @(posedge CLK) disable iff (!resetn) (loading_move || executing_move) |-> slot_full
  );

endmodule

// ==== hw/dda_timer.sv ====
`timescale 1ns/1ns

module dda_timer (
  input logic CLK,
  input logic resetn,
  input logic dda_tick,
  input logic loading_move,
  input logic executing_move,
  input logic signed [63:0] increment,
  input logic signed [63:0] incrementincrement,
  output logic step
);

  logic [63:0] position;
  logic signed [63:0] velocity;
  logic [64:0] position_sum;

  // Carry out of the accumulator marks one step
  assign position_sum = {1'b0, position} + {1'b0, velocity};

  always_ff @(posedge CLK) begin
    if (loading_move) begin
      position <= '0;
      velocity <= increment;
    end else if (dda_tick && executing_move) begin
      position <= position_sum[63:0];
      velocity <= velocity + incrementincrement;
    end
  end

  // Pulse held for one full tick period
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step <= 1'b0;
    end else if (dda_tick) begin
      step <= executing_move & position_sum[64];
    end
  end

endmodule

// ==== hw/step_encoder.sv ====
`timescale 1ns/1ns

module step_encoder (
  input logic CLK,
  input logic resetn,
  input logic step,
  input logic dir,
  output logic signed [31:0] count
);

  logic step_q;
  logic step_rise;

  assign step_rise = step & ~step_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step_q <= 1'b0;
      count <= '0;
    end else begin
      step_q <= step;
      // dir high counts forward
      if (step_rise) begin
        count <= dir ? count + 32'sd1 : count - 32'sd1;
      end
    end
  end

endmodule

// ==== hw/stepper_top.sv ====
`timescale 1ns/1ns

module stepper_top #(
  parameter int motor_count = 2,
  parameter int move_duration_bits = 32
) (
  input logic CLK,
  input logic resetn,
  input logic sck,
  input logic cs,
  input logic copi,
  output logic cipo,
  output logic [motor_count-1:0] step,
  output logic [motor_count-1:0] dir,
  output logic [motor_count-1:0] enable,
  output logic [2:0] microsteps,
  output logic [7:0] current,
  output logic buffer_dtr,
  output logic move_done
);

  localparam int depth = stepper_pkg::move_buffer_depth;

  stepper_pkg::spi_word_t word_data;
  stepper_pkg::spi_word_t reply_data;
  logic word_strobe;

  logic [7:0] clock_divisor;
  logic [depth-1:0] stepready;
  logic [move_duration_bits-1:0] slot_duration [depth];
  logic [motor_count-1:0] slot_dir [depth];
  logic signed [63:0] slot_increment [depth][motor_count];
  logic signed [63:0] slot_incrementincrement [depth][motor_count];

  logic move_index;
  logic dda_tick;
  logic loading_move;
  logic executing_move;
  logic signed [31:0] step_count [motor_count];

  // Direction follows the move being played
  assign dir = slot_dir[move_index];

  spi_word spi_word_inst (
    .CLK(CLK),
    .resetn(resetn),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .reply_data(reply_data),
    .cipo(cipo),
    .word_data(word_data),
    .word_strobe(word_strobe)
  );

  command_decoder #(
    .motor_count(motor_count),
    .move_duration_bits(move_duration_bits)
  ) command_decoder_inst (
    .CLK(CLK),
    .resetn(resetn),
    .word_data(word_data),
    .word_strobe(word_strobe),
    .move_index(move_index),
    .step_count(step_count),
    .reply_data(reply_data),
    .enable(enable),
    .microsteps(microsteps),
    .current(current),
    .clock_divisor(clock_divisor),
    .stepready(stepready),
    .slot_duration(slot_duration),
    .slot_dir(slot_dir),
    .slot_increment(slot_increment),
    .slot_incrementincrement(slot_incrementincrement)
  );

  dda_fsm #(
    .move_duration_bits(move_duration_bits)
  ) dda_fsm_inst (
    .CLK(CLK),
    .resetn(resetn),
    .clock_divisor(clock_divisor),
    .stepready(stepready),
    .slot_duration(slot_duration),
    .dda_tick(dda_tick),
    .loading_move(loading_move),
    .executing_move(executing_move),
    .move_done(move_done),
    .buffer_dtr(buffer_dtr),
    .move_index(move_index)
  );

  // One DDA timer and one step counter per axis
  for (genvar i = 0; i < motor_count; i++) begin : axis_gen
    dda_timer dda_timer_inst (
      .CLK(CLK),
      .resetn(resetn),
      .dda_tick(dda_tick),
      .loading_move(loading_move),
      .executing_move(executing_move),
      .increment(slot_increment[move_index][i]),
      .incrementincrement(slot_incrementincrement[move_index][i]),
      .step(step[i])
    );

    step_encoder step_encoder_inst (
      .CLK(CLK),
      .resetn(resetn),
      .step(step[i]),
      .dir(dir[i]),
      .count(step_count[i])
    );
  end

endmodule

// ==== sim/tb_stepper_tasks.svh ====
`ifndef TB_STEPPER_TASKS_SVH
`define TB_STEPPER_TASKS_SVH

// Step past n rising edges so that drives land just after the edge
task automatic cycles(input int n);
  repeat (n) @(posedge CLK);
  #1;
endtask

task automatic fail_run();
  $display("TEST FAIL");
  $fatal(1, "Stopping at the first error");
endtask

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected 0x%016h, actual 0x%016h", name, expected, actual);
    fail_run();
  end
endtask

// Mode 0, 4-cycle sck phases, MSB first in both directions
task automatic spi_xfer_word(input logic [63:0] tx, output logic [63:0] rx);
  cs = 1'b0;
  cycles(4);
  for (int i = 63; i >= 0; i--) begin
    copi = tx[i];
    cycles(4);
    rx[i] = cipo;
    sck = 1'b1;
    cycles(4);
    sck = 1'b0;
  end
  cycles(4);
  cs = 1'b1;
  copi = 1'b0;
  // Leaves room for the strobe and the next reply
  cycles(8);
endtask

task automatic wait_dtr_high(input string what);
  int n;
  n = 0;
  while (buffer_dtr !== 1'b1) begin
    if (n == dtr_timeout) begin
      $display("Timeout: buffer_dtr never went high before %s", what);
      fail_run();
    end
    cycles(1);
    n++;
  end
endtask

task automatic wait_moves_done(input int count);
  int n;
  n = 0;
  while (done_seen < count) begin
    if (n == move_timeout) begin
      $display("Timeout: only %0d of %0d moves signalled move_done", done_seen, count);
      fail_run();
    end
    cycles(1);
    n++;
  end
endtask

`endif

// ==== sim/tb_stepper.sv ====
`timescale 1ns/1ns

module tb_stepper;

  localparam int motor_count = 2;
  localparam int move_count = 3;
  localparam int dtr_timeout = 20000;
  localparam int move_timeout = 20000;
  localparam logic [7:0] tick_div = 8'd4;
  localparam int sync_none = 0;
  localparam int sync_dtr = 1;
  localparam int sync_idle = 2;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  logic [motor_count-1:0] step;
  logic [motor_count-1:0] dir;
  logic [motor_count-1:0] enable;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic buffer_dtr;
  logic move_done;

  // Stimulus table, one entry per SPI word
  string tbl_name[$];
  logic [63:0] tbl_word[$];
  logic tbl_check[$];
  logic [63:0] tbl_reply[$];
  int tbl_sync[$];

  logic [31:0] mv_dur [move_count];
  logic [63:0] mv_inc [move_count][motor_count];
  logic [motor_count-1:0] mv_dir [move_count];

  int done_seen;
  int cyc;
  int done_cycle [move_count];
  int step_seen [move_count][motor_count];
  logic dtr_low_seen;
  logic [motor_count-1:0] step_q;

  `include "tb_stepper_tasks.svh"

  stepper_top #(
    .motor_count(motor_count),
    .move_duration_bits(32)
  ) stepper_top_inst (
    .CLK(CLK),
    .resetn(resetn),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .step(step),
    .dir(dir),
    .enable(enable),
    .microsteps(microsteps),
    .current(current),
    .buffer_dtr(buffer_dtr),
    .move_done(move_done)
  );

  always #2 CLK = ~CLK;

  // Steps per move and axis, dir at each step, move_done times
  always @(negedge CLK) begin
    if (resetn) begin
      cyc++;
      for (int k = 0; k < motor_count; k++) begin
        if (step[k] && !step_q[k] && done_seen < move_count) begin
          step_seen[done_seen][k]++;
          check_value($sformatf("dir_move%0d", done_seen), 64'(mv_dir[done_seen]), 64'(dir));
        end
      end
      step_q = step;
      if (!buffer_dtr) begin
        dtr_low_seen = 1'b1;
      end
      if (move_done && done_seen < move_count) begin
        done_cycle[done_seen] = cyc;
        done_seen++;
      end
    end
  end

  // Carries out of a 64-bit accumulator over dur ticks
  function automatic logic [63:0] expected_steps(input logic [31:0] dur, input logic [63:0] inc);
    logic [127:0] prod;
    prod = 128'(dur) * 128'(inc);
    return prod[127:64];
  endfunction

  function automatic logic [63:0] expected_position(input int axis, input int moves);
    logic [63:0] sum;
    sum = '0;
    for (int m = 0; m < moves; m++) begin
      if (mv_dir[m][axis]) begin
        sum = sum + expected_steps(mv_dur[m], mv_inc[m][axis]);
      end else begin
        sum = sum - expected_steps(mv_dur[m], mv_inc[m][axis]);
      end
    end
    return sum;
  endfunction

  function automatic logic [63:0] header_word(input logic [7:0] cmd, input logic [55:0] arg);
    stepper_pkg::spi_word_t w;
    w.header.cmd = cmd;
    w.header.arg = arg;
    return w.raw;
  endfunction

  task automatic add_entry(input string name, input logic [63:0] word, input logic check,
                           input logic [63:0] reply, input int sync);
    tbl_name.push_back(name);
    tbl_word.push_back(word);
    tbl_check.push_back(check);
    tbl_reply.push_back(reply);
    tbl_sync.push_back(sync);
  endtask

  // Header, duration, then increment and acceleration per axis
  task automatic add_move(input string name, input int m, input int sync, input logic check);
    add_entry({name, "_header"},
              header_word(stepper_pkg::cmd_coordinated_step, 56'(mv_dir[m])), check, 0, sync);
    add_entry({name, "_duration"}, 64'(mv_dur[m]), check, 0, sync_none);
    for (int k = 0; k < motor_count; k++) begin
      add_entry($sformatf("%s_inc%0d", name, k), mv_inc[m][k], check,
                expected_position(k, m), sync_none);
      add_entry($sformatf("%s_accel%0d", name, k), 64'd0, check, 0, sync_none);
    end
  endtask

  task automatic check_move_steps(input int m);
    for (int k = 0; k < motor_count; k++) begin
      check_value($sformatf("steps_move%0d_axis%0d", m, k),
                  expected_steps(mv_dur[m], mv_inc[m][k]), 64'(step_seen[m][k]));
    end
  endtask

  // Both queued moves finished, second one chained straight after the first
  task automatic check_moves_played();
    int span;
    wait_moves_done(2);
    check_move_steps(0);
    check_move_steps(1);
    check_value("buffer_dtr_went_low", 1, 64'(dtr_low_seen));
    check_value("buffer_dtr_idle", 1, 64'(buffer_dtr));
    span = done_cycle[1] - done_cycle[0];
    check_value("move2_length", 1,
                64'(span >= 4 * mv_dur[1] - 4 && span <= 4 * mv_dur[1] + 4));
  endtask

  initial begin
    logic [63:0] reply;
    int gap;
    CLK = 1'b0;
    resetn = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    done_seen = 0;
    cyc = 0;
    dtr_low_seen = 1'b0;
    step_q = '0;
    for (int m = 0; m < move_count; m++) begin
      done_cycle[m] = 0;
      for (int k = 0; k < motor_count; k++) begin
        step_seen[m][k] = 0;
      end
    end
    void'($urandom(32'hfd3d));

    mv_dur[0] = 32'd1000;
    mv_inc[0][0] = 64'h4000_0000_0000_0000;
    mv_inc[0][1] = 64'h1555_5555_5555_5555;
    mv_dir[0] = 2'b01;
    mv_dur[1] = 32'd600;
    mv_inc[1][0] = 64'h2000_0000_0000_0000;
    mv_inc[1][1] = 64'h3333_3333_3333_3333;
    mv_dir[1] = 2'b10;
    // Third move only reads back the counters
    mv_dur[2] = 32'd8;
    mv_inc[2][0] = 64'd0;
    mv_inc[2][1] = 64'd0;
    mv_dir[2] = 2'b11;

    add_entry("enable", header_word(stepper_pkg::cmd_motor_enable, 56'h3), 1, 0, sync_none);
    add_entry("motorconfig", header_word(stepper_pkg::cmd_motorconfig, 56'hc8_05), 1, 0,
              sync_none);
    add_entry("api_version", header_word(stepper_pkg::cmd_api_version, 56'h0), 1, 0,
              sync_none);
    add_entry("api_dummy", 64'd0, 1,
              {40'd0, stepper_pkg::version_major, stepper_pkg::version_minor,
               stepper_pkg::version_patch}, sync_none);
    add_entry("unknown", header_word(8'h77, 56'h0), 1, 0, sync_none);
    add_entry("clk_divisor", header_word(stepper_pkg::cmd_clk_divisor, 56'(tick_div)), 1, 0,
              sync_none);
    add_move("move1", 0, sync_dtr, 1'b1);
    add_move("move2", 1, sync_dtr, 1'b0);
    add_move("move3", 2, sync_idle, 1'b1);

    cycles(4);
    resetn = 1'b1;
    cycles(1);
    check_value("reset_microsteps", 64'(stepper_pkg::reset_microsteps), 64'(microsteps));
    check_value("reset_current", 64'(stepper_pkg::reset_current), 64'(current));
    check_value("reset_enable", 0, 64'(enable));
    check_value("reset_buffer_dtr", 1, 64'(buffer_dtr));
    check_value("reset_step", 0, 64'(step));
    check_value("reset_move_done", 0, 64'(move_done));
    check_value("reset_cipo", 0, 64'(cipo));

    for (int i = 0; i < tbl_word.size(); i++) begin
      if (tbl_sync[i] == sync_dtr) begin
        wait_dtr_high(tbl_name[i]);
      end else if (tbl_sync[i] == sync_idle) begin
        check_moves_played();
      end
      spi_xfer_word(tbl_word[i], reply);
      if (tbl_check[i]) begin
        check_value(tbl_name[i], tbl_reply[i], reply);
      end
      gap = $urandom % 8;
      if (gap > 0) begin
        cycles(gap);
      end
    end

    wait_moves_done(3);
    check_move_steps(2);
    check_value("enable", 64'h3, 64'(enable));
    check_value("current", 64'd200, 64'(current));
    check_value("microsteps", 64'd5, 64'(microsteps));
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+sim
hw/stepper_pkg.sv
hw/spi_word.sv
hw/command_decoder.sv
hw/dda_fsm.sv
hw/dda_timer.sv
hw/step_encoder.sv
hw/stepper_top.sv
sim/tb_stepper.sv
